// File: bev_defines.svh
// beverage box widths and fields
`ifndef BEV_DEFINES_SVH
`define BEV_DEFINES_SVH

// ingredient level and its carry-extended sum
`define BEV_ING_W      12
`define BEV_ING_EXT_W  13
`define BEV_NUM_ING    4
`define BEV_ING_MAX    12'd4095

// order and record widths
`define BEV_BOX_W      8
`define BEV_DATA_W     64
`define BEV_MONTH_W    4
`define BEV_DAY_W      5
`define BEV_DATE_W     9

// cup volumes, sized to the carry-extended width
`define BEV_VOL_L      13'd960
`define BEV_VOL_M      13'd720
`define BEV_VOL_S      13'd480

// dram record field positions
`define BEV_BT_LSB     52
`define BEV_GT_LSB     40
`define BEV_MONTH_LSB  32
`define BEV_MK_LSB     20
`define BEV_PJ_LSB     8
`define BEV_DAY_LSB    0

`endif

// File: bev_pkg.sv
// beverage controller types
`default_nettype none

package bev_pkg;

    // order actions
    typedef enum logic [1:0] {
        make_drink,
        supply,
        check_date
    } action_t;

    // drink menu, encoded 0 to 7
    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    // cup sizes
    typedef enum logic [1:0] {
        size_l,
        size_m,
        size_s
    } bev_size_t;

    // result codes
    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2,
        ing_of = 2'd3
    } err_msg_t;

    // order fsm
    typedef enum logic [2:0] {
        idle,
        order_in,
        supply_in,
        dram_read,
        judge,
        update,
        dram_write,
        report
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: bev_order_ctrl.sv
// beverage order controller
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module bev_order_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sel_action_valid,
    input  bev_pkg::action_t       action,
    input  logic                   date_valid,
    input  logic [`BEV_DATE_W-1:0] date,
    input  logic                   box_no_valid,
    input  logic [`BEV_BOX_W-1:0]  box_no,
    input  logic                   sup_done,
    input  logic                   c_out_valid,
    input  bev_pkg::err_msg_t      err_msg_q,
    output logic [`BEV_BOX_W-1:0]  c_addr,
    output logic                   c_r_wb,
    output logic                   c_in_valid,
    output bev_pkg::action_t       order_action,
    output logic [`BEV_DATE_W-1:0] order_date,
    output logic                   box_load,
    output logic                   box_judge,
    output logic                   box_commit,
    output logic                   out_valid,
    output bev_pkg::err_msg_t      err_msg,
    output logic                   complete
);

    bev_pkg::ctrl_state_t state;
    bev_pkg::ctrl_state_t state_next;
    logic                 write_skip;

    // check date never writes, a failed make leaves the box alone
    assign write_skip = (order_action == bev_pkg::check_date) ||
                        (order_action == bev_pkg::make_drink && err_msg_q != bev_pkg::no_err);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bev_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            bev_pkg::idle: begin
                if (sel_action_valid) state_next = bev_pkg::order_in;
            end
            bev_pkg::order_in: begin
                // box number closes the order fields
                if (box_no_valid) begin
                    if (order_action == bev_pkg::supply) state_next = bev_pkg::supply_in;
                    else state_next = bev_pkg::dram_read;
                end
            end
            bev_pkg::supply_in: begin
                if (sup_done) state_next = bev_pkg::dram_read;
            end
            bev_pkg::dram_read: begin
                if (c_out_valid) state_next = bev_pkg::judge;
            end
            bev_pkg::judge: begin
                state_next = bev_pkg::update;
            end
            bev_pkg::update: begin
                if (write_skip) state_next = bev_pkg::report;
                else state_next = bev_pkg::dram_write;
            end
            bev_pkg::dram_write: begin
                if (c_out_valid) state_next = bev_pkg::report;
            end
            bev_pkg::report: begin
                state_next = bev_pkg::idle;
            end
            default: state_next = bev_pkg::idle;
        endcase
    end

    // order fields, each taken on its own pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            order_action <= bev_pkg::make_drink;
            order_date   <= '0;
            c_addr       <= '0;
        end else begin
            if (sel_action_valid) order_action <= action;
            if (date_valid) order_date <= date;
            if (box_no_valid) c_addr <= box_no;
        end
    end

    // one-cycle strobe on entry to either dram state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_in_valid <= 1'b0;
        end else begin
            c_in_valid <= (state != bev_pkg::dram_read && state_next == bev_pkg::dram_read) ||
                          (state != bev_pkg::dram_write && state_next == bev_pkg::dram_write);
        end
    end

    // read unless writing
    assign c_r_wb = (state != bev_pkg::dram_write);

    // strobes to lanes and box check
    assign box_load   = (state == bev_pkg::dram_read) && c_out_valid;
    assign box_judge  = (state == bev_pkg::judge);
    assign box_commit = (state == bev_pkg::update) && !write_skip;

    // result only during report
    assign out_valid = (state == bev_pkg::report);
    assign err_msg   = out_valid ? err_msg_q : bev_pkg::no_err;
    assign complete  = out_valid && (err_msg_q == bev_pkg::no_err);

endmodule

`default_nettype wire

// File: bev_recipe.sv
// recipe and supply change values
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module bev_recipe (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sel_action_valid,
    input  bev_pkg::bev_type_t        bev_type,
    input  logic                      type_valid,
    input  logic                      size_valid,
    input  bev_pkg::bev_size_t        bev_size,
    input  logic                      box_sup_valid,
    input  logic [`BEV_ING_W-1:0]     ing_sup,
    output logic [`BEV_ING_EXT_W-1:0] ing_delta [`BEV_NUM_ING],
    output logic                      sup_done
);

    bev_pkg::bev_type_t        type_q;
    bev_pkg::bev_size_t        size_q;
    logic                      size_valid_d;
    logic [1:0]                sup_cnt;
    logic [2:0]                quarters [`BEV_NUM_ING];
    logic [`BEV_ING_EXT_W-1:0] cup_quarter;
    logic [`BEV_ING_EXT_W-1:0] amount [`BEV_NUM_ING];

    // quarters per lane: bt, gt, mk, pj
    always_comb begin
        case (type_q)
            bev_pkg::black_tea:                quarters = '{3'd4, 3'd0, 3'd0, 3'd0};
            bev_pkg::milk_tea:                 quarters = '{3'd3, 3'd0, 3'd1, 3'd0};
            bev_pkg::extra_milk_tea:           quarters = '{3'd2, 3'd0, 3'd2, 3'd0};
            bev_pkg::green_tea:                quarters = '{3'd0, 3'd4, 3'd0, 3'd0};
            bev_pkg::green_milk_tea:           quarters = '{3'd0, 3'd2, 3'd2, 3'd0};
            bev_pkg::pineapple_juice:          quarters = '{3'd0, 3'd0, 3'd0, 3'd4};
            bev_pkg::super_pineapple_tea:      quarters = '{3'd2, 3'd0, 3'd0, 3'd2};
            bev_pkg::super_pineapple_milk_tea: quarters = '{3'd2, 3'd0, 3'd1, 3'd1};
            default:                           quarters = '{3'd0, 3'd0, 3'd0, 3'd0};
        endcase
    end

    // a quarter of the cup
    always_comb begin
        case (size_q)
            bev_pkg::size_l: cup_quarter = (`BEV_VOL_L >> 2);
            bev_pkg::size_m: cup_quarter = (`BEV_VOL_M >> 2);
            default:         cup_quarter = (`BEV_VOL_S >> 2);
        endcase
    end

    always_comb begin
        for (int i = 0; i < `BEV_NUM_ING; i++) begin
            amount[i] = {{(`BEV_ING_EXT_W-3){1'b0}}, quarters[i]} * cup_quarter;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            type_q       <= bev_pkg::black_tea;
            size_q       <= bev_pkg::size_l;
            size_valid_d <= 1'b0;
            sup_cnt      <= '0;
            sup_done     <= 1'b0;
            for (int i = 0; i < `BEV_NUM_ING; i++) ing_delta[i] <= '0;
        end else begin
            if (type_valid) type_q <= bev_type;
            if (size_valid) size_q <= bev_size;
            size_valid_d <= size_valid;
            // last of four supply pulses
            sup_done <= box_sup_valid && (sup_cnt == 2'd3);
            if (sel_action_valid) begin
                sup_cnt <= '0;
                for (int i = 0; i < `BEV_NUM_ING; i++) ing_delta[i] <= '0;
            end else if (size_valid_d) begin
                // two's complement, lane carry then means borrow
                for (int i = 0; i < `BEV_NUM_ING; i++) ing_delta[i] <= -amount[i];
            end else if (box_sup_valid) begin
                ing_delta[sup_cnt] <= {1'b0, ing_sup};
                sup_cnt            <= sup_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bev_ing_lane.sv
// one ingredient level
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module bev_ing_lane (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      box_load,
    input  logic [`BEV_ING_W-1:0]     load_level,
    input  logic [`BEV_ING_EXT_W-1:0] ing_delta,
    input  logic                      box_commit,
    output logic [`BEV_ING_W-1:0]     ing_level,
    output logic                      ing_carry
);

    logic [`BEV_ING_EXT_W-1:0] sum;

    // top bit is overflow on supply, borrow on make
    assign sum       = {1'b0, ing_level} + ing_delta;
    assign ing_carry = sum[`BEV_ING_EXT_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ing_level <= '0;
        end else if (box_load) begin
            ing_level <= load_level;
        end else if (box_commit) begin
            // saturate on overflow
            if (ing_carry) ing_level <= `BEV_ING_MAX;
            else ing_level <= sum[`BEV_ING_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: bev_box_check.sv
// box date and error judgement
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module bev_box_check (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    box_load,
    input  logic [`BEV_MONTH_W-1:0] load_month,
    input  logic [`BEV_DAY_W-1:0]   load_day,
    input  logic                    box_judge,
    input  logic                    box_commit,
    input  bev_pkg::action_t        order_action,
    input  logic [`BEV_DATE_W-1:0]  order_date,
    input  logic [`BEV_NUM_ING-1:0] ing_carry,
    output bev_pkg::err_msg_t       err_msg_q,
    output logic [`BEV_MONTH_W-1:0] box_month,
    output logic [`BEV_DAY_W-1:0]   box_day
);

    logic expired;
    logic any_carry;

    // month sits above day, so one compare covers both
    assign expired   = order_date > {box_month, box_day};
    assign any_carry = |ing_carry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            box_month <= '0;
            box_day   <= '0;
        end else if (box_load) begin
            box_month <= load_month;
            box_day   <= load_day;
        end else if (box_commit && order_action == bev_pkg::supply) begin
            // supply restamps the box
            {box_month, box_day} <= order_date;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_msg_q <= bev_pkg::no_err;
        end else if (box_judge) begin
            case (order_action)
                bev_pkg::make_drink: begin
                    if (expired) err_msg_q <= bev_pkg::no_exp;
                    else if (any_carry) err_msg_q <= bev_pkg::no_ing;
                    else err_msg_q <= bev_pkg::no_err;
                end
                bev_pkg::supply: err_msg_q <= any_carry ? bev_pkg::ing_of : bev_pkg::no_err;
                bev_pkg::check_date: err_msg_q <= expired ? bev_pkg::no_exp : bev_pkg::no_err;
                default: err_msg_q <= bev_pkg::no_err;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: bev_top.sv
// beverage box controller top
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module bev_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sel_action_valid,
    input  bev_pkg::action_t       action,
    input  logic                   type_valid,
    input  bev_pkg::bev_type_t     bev_type,
    input  logic                   size_valid,
    input  bev_pkg::bev_size_t     bev_size,
    input  logic                   date_valid,
    input  logic [`BEV_DATE_W-1:0] date,
    input  logic                   box_no_valid,
    input  logic [`BEV_BOX_W-1:0]  box_no,
    input  logic                   box_sup_valid,
    input  logic [`BEV_ING_W-1:0]  ing_sup,
    output logic                   out_valid,
    output bev_pkg::err_msg_t      err_msg,
    output logic                   complete,
    output logic [`BEV_BOX_W-1:0]  c_addr,
    output logic                   c_r_wb,
    output logic                   c_in_valid,
    output logic [`BEV_DATA_W-1:0] c_data_w,
    input  logic                   c_out_valid,
    input  logic [`BEV_DATA_W-1:0] c_data_r
);

    bev_pkg::action_t          order_action;
    bev_pkg::err_msg_t         err_msg_q;
    logic [`BEV_DATE_W-1:0]    order_date;
    logic                      box_load;
    logic                      box_judge;
    logic                      box_commit;
    logic                      sup_done;
    logic [`BEV_ING_EXT_W-1:0] ing_delta [`BEV_NUM_ING];
    logic [`BEV_ING_W-1:0]     ing_level [`BEV_NUM_ING];
    logic [`BEV_NUM_ING-1:0]   ing_carry;
    logic [`BEV_MONTH_W-1:0]   box_month;
    logic [`BEV_DAY_W-1:0]     box_day;

    bev_order_ctrl u_ctrl (
        .clk, .rst_n, .sel_action_valid, .action, .date_valid, .date,
        .box_no_valid, .box_no, .sup_done, .c_out_valid, .err_msg_q,
        .c_addr, .c_r_wb, .c_in_valid, .order_action, .order_date,
        .box_load, .box_judge, .box_commit, .out_valid, .err_msg, .complete
    );

    bev_recipe u_recipe (
        .clk, .rst_n, .sel_action_valid, .bev_type, .type_valid, .size_valid,
        .bev_size, .box_sup_valid, .ing_sup, .ing_delta, .sup_done
    );

    // lane order is bt, gt, mk, pj
    for (genvar i = 0; i < `BEV_NUM_ING; i++) begin : gen_lane
        localparam int lane_lsb = (i == 0) ? `BEV_BT_LSB :
                                  (i == 1) ? `BEV_GT_LSB :
                                  (i == 2) ? `BEV_MK_LSB : `BEV_PJ_LSB;
        bev_ing_lane u_lane (
            .clk, .rst_n, .box_load,
            .load_level (c_data_r[lane_lsb +: `BEV_ING_W]),
            .ing_delta  (ing_delta[i]),
            .box_commit,
            .ing_level  (ing_level[i]),
            .ing_carry  (ing_carry[i])
        );
    end

    bev_box_check u_box_check (
        .clk, .rst_n, .box_load,
        .load_month (c_data_r[`BEV_MONTH_LSB +: `BEV_MONTH_W]),
        .load_day   (c_data_r[`BEV_DAY_LSB +: `BEV_DAY_W]),
        .box_judge, .box_commit, .order_action, .order_date, .ing_carry,
        .err_msg_q, .box_month, .box_day
    );

    // month and day fields are 8 bits wide, zero-extended
    assign c_data_w = {ing_level[0], ing_level[1], 4'b0, box_month,
                       ing_level[2], ing_level[3], 3'b0, box_day};

endmodule

`default_nettype wire

// File: tb_bev.sv
// beverage controller testbench
`timescale 1ns/1ps
`default_nettype none
`include "bev_defines.svh"

module tb_bev;

    // watchdog budget
    localparam int num_orders       = 40;
    localparam int cycles_per_order = 200;
    localparam int clk_period       = 8;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   sel_action_valid;
    bev_pkg::action_t       action;
    logic                   type_valid;
    bev_pkg::bev_type_t     bev_type;
    logic                   size_valid;
    bev_pkg::bev_size_t     bev_size;
    logic                   date_valid;
    logic [`BEV_DATE_W-1:0] date;
    logic                   box_no_valid;
    logic [`BEV_BOX_W-1:0]  box_no;
    logic                   box_sup_valid;
    logic [`BEV_ING_W-1:0]  ing_sup;
    logic                   out_valid;
    bev_pkg::err_msg_t      err_msg;
    logic                   complete;
    logic [`BEV_BOX_W-1:0]  c_addr;
    logic                   c_r_wb;
    logic                   c_in_valid;
    logic [`BEV_DATA_W-1:0] c_data_w;
    logic                   c_out_valid = 1'b0;
    logic [`BEV_DATA_W-1:0] c_data_r = '0;

    // dram model state
    logic [`BEV_DATA_W-1:0] mem [256];
    logic [`BEV_BOX_W-1:0]  req_addr;
    logic                   req_read;
    logic [`BEV_DATA_W-1:0] req_data;
    int                     req_delay;
    int                     num_writes = 0;
    time                    resp_time  = 0;

    integer seed;
    int     num_checks = 0;
    int     num_errors = 0;

    bev_top UUT (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // field position of each lane in the record
    function automatic int lane_lsb(input int lane);
        case (lane)
            0: return `BEV_BT_LSB;
            1: return `BEV_GT_LSB;
            2: return `BEV_MK_LSB;
            default: return `BEV_PJ_LSB;
        endcase
    endfunction

    function automatic int level_of(input logic [63:0] rec, input int lane);
        return {20'd0, rec[lane_lsb(lane) +: `BEV_ING_W]};
    endfunction

    function automatic logic [8:0] date_of(input logic [63:0] rec);
        return {rec[`BEV_MONTH_LSB +: 4], rec[`BEV_DAY_LSB +: 5]};
    endfunction

    function automatic logic [63:0] with_level(input logic [63:0] rec, input int lane,
                                               input int val);
        logic [63:0] r;
        r = rec;
        r[lane_lsb(lane) +: `BEV_ING_W] = val[11:0];
        return r;
    endfunction

    // month and day each fill an 8-bit field
    function automatic logic [63:0] with_date(input logic [63:0] rec, input logic [8:0] d);
        logic [63:0] r;
        r = rec;
        r[`BEV_MONTH_LSB +: 8] = {4'd0, d[8:5]};
        r[`BEV_DAY_LSB +: 8]   = {3'd0, d[4:0]};
        return r;
    endfunction

    function automatic logic [8:0] pack_date(input int m, input int d);
        return {m[3:0], d[4:0]};
    endfunction

    function automatic logic [63:0] make_record(input int bt, input int gt, input int mk,
                                                input int pj, input logic [8:0] d);
        logic [63:0] r;
        r = with_level(64'd0, 0, bt);
        r = with_level(r, 1, gt);
        r = with_level(r, 2, mk);
        r = with_level(r, 3, pj);
        return with_date(r, d);
    endfunction

    // cup quarters packed one nibble per lane with black tea on top
    function automatic int quarter_count(input bev_pkg::bev_type_t t, input int lane);
        logic [15:0] q;
        case (t)
            bev_pkg::black_tea:                q = 16'h4000;
            bev_pkg::milk_tea:                 q = 16'h3010;
            bev_pkg::extra_milk_tea:           q = 16'h2020;
            bev_pkg::green_tea:                q = 16'h0400;
            bev_pkg::green_milk_tea:           q = 16'h0220;
            bev_pkg::pineapple_juice:          q = 16'h0004;
            bev_pkg::super_pineapple_tea:      q = 16'h2002;
            default:                           q = 16'h2011;
        endcase
        return {28'd0, q[(3 - lane) * 4 +: 4]};
    endfunction

    function automatic int cup_volume(input bev_pkg::bev_size_t s);
        case (s)
            bev_pkg::size_l: return 960;
            bev_pkg::size_m: return 720;
            default:         return 480;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        num_checks++;
        if (got !== expected) begin
            num_errors++;
            $display("FAILED %s: got %0h, expected %0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic read_back(input logic [7:0] box, input logic [63:0] expected);
        check_value($sformatf("record %0d", box), mem[box], expected);
    endtask

    task automatic send_action(input bev_pkg::action_t a);
        @(negedge clk);
        action = a;
        sel_action_valid = 1'b1;
        @(negedge clk);
        sel_action_valid = 1'b0;
    endtask

    task automatic send_date(input logic [8:0] d);
        @(negedge clk);
        date = d;
        date_valid = 1'b1;
        @(negedge clk);
        date_valid = 1'b0;
    endtask

    task automatic send_box(input logic [7:0] box);
        @(negedge clk);
        box_no = box;
        box_no_valid = 1'b1;
        @(negedge clk);
        box_no_valid = 1'b0;
    endtask

    // wait for the report cycle and check the result and the stored record
    task automatic collect_result(input logic [7:0] box, input bev_pkg::err_msg_t exp_err,
                                  input bit exp_write, input logic [63:0] exp_rec);
        int writes_before;
        writes_before = num_writes;
        while (!out_valid) begin
            check_value("err_msg", 64'(err_msg), 64'd0);
            check_value("complete", 64'(complete), 64'd0);
            @(negedge clk);
        end
        check_value("err_msg", 64'(err_msg), 64'(exp_err));
        check_value("complete", 64'(complete), 64'(exp_err == bev_pkg::no_err));
        // report trails the last dram response by 1 cycle after a write, 3 without
        check_value("out_valid latency", 64'(($time - resp_time) / clk_period),
                    exp_write ? 64'd1 : 64'd3);
        @(negedge clk);
        // single-cycle report
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("dram writes", 64'(num_writes - writes_before), 64'(exp_write));
        read_back(box, exp_rec);
    endtask

    task automatic do_make(input logic [7:0] box, input bev_pkg::bev_type_t t,
                           input bev_pkg::bev_size_t s, input logic [8:0] d);
        logic [63:0]       old_rec;
        logic [63:0]       exp_rec;
        bev_pkg::err_msg_t exp_err;
        int                need;
        old_rec = mem[box];
        exp_rec = old_rec;
        exp_err = bev_pkg::no_err;
        if (d > date_of(old_rec)) begin
            exp_err = bev_pkg::no_exp;
        end else begin
            for (int i = 0; i < 4; i++) begin
                need = quarter_count(t, i) * cup_volume(s) / 4;
                if (level_of(old_rec, i) < need) exp_err = bev_pkg::no_ing;
                else exp_rec = with_level(exp_rec, i, level_of(old_rec, i) - need);
            end
            // a failed make leaves the record as it was
            if (exp_err != bev_pkg::no_err) exp_rec = old_rec;
        end
        send_action(bev_pkg::make_drink);
        @(negedge clk);
        bev_type = t;
        type_valid = 1'b1;
        @(negedge clk);
        type_valid = 1'b0;
        @(negedge clk);
        bev_size = s;
        size_valid = 1'b1;
        @(negedge clk);
        size_valid = 1'b0;
        send_date(d);
        send_box(box);
        collect_result(box, exp_err, exp_err == bev_pkg::no_err, exp_rec);
    endtask

    // sup packs four 12-bit amounts with black tea on top
    task automatic do_supply(input logic [7:0] box, input logic [8:0] d,
                             input logic [47:0] sup);
        logic [63:0]       exp_rec;
        bev_pkg::err_msg_t exp_err;
        int                sum;
        exp_rec = mem[box];
        exp_err = bev_pkg::no_err;
        for (int i = 0; i < 4; i++) begin
            sum = level_of(exp_rec, i) + {20'd0, sup[(3 - i) * 12 +: 12]};
            if (sum > 4095) begin
                sum = 4095;
                exp_err = bev_pkg::ing_of;
            end
            exp_rec = with_level(exp_rec, i, sum);
        end
        exp_rec = with_date(exp_rec, d);
        send_action(bev_pkg::supply);
        send_date(d);
        send_box(box);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            ing_sup = sup[(3 - i) * 12 +: 12];
            box_sup_valid = 1'b1;
            @(negedge clk);
            box_sup_valid = 1'b0;
        end
        collect_result(box, exp_err, 1'b1, exp_rec);
    endtask

    task automatic do_check_date(input logic [7:0] box, input logic [8:0] d);
        bev_pkg::err_msg_t exp_err;
        exp_err = (d > date_of(mem[box])) ? bev_pkg::no_exp : bev_pkg::no_err;
        send_action(bev_pkg::check_date);
        send_date(d);
        send_box(box);
        collect_result(box, exp_err, 1'b0, mem[box]);
    endtask

    task automatic test_reset();
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("c_in_valid", 64'(c_in_valid), 64'd0);
        check_value("complete", 64'(complete), 64'd0);
        check_value("err_msg", 64'(err_msg), 64'd0);
        check_value("c_r_wb", 64'(c_r_wb), 64'd1);
    endtask

    task automatic test_make_ok();
        mem[1] = make_record(3000, 3000, 3000, 3000, pack_date(12, 20));
        do_make(8'd1, bev_pkg::milk_tea, bev_pkg::size_l, pack_date(12, 10));
        // same day still counts as fresh
        do_make(8'd1, bev_pkg::super_pineapple_milk_tea, bev_pkg::size_s, pack_date(12, 20));
        do_make(8'd1, bev_pkg::green_milk_tea, bev_pkg::size_m, pack_date(3, 1));
    endtask

    task automatic test_make_fail();
        do_make(8'd1, bev_pkg::black_tea, bev_pkg::size_l, pack_date(12, 21));
        mem[2] = make_record(100, 4000, 4000, 4000, pack_date(6, 15));
        do_make(8'd2, bev_pkg::black_tea, bev_pkg::size_s, pack_date(6, 1));
    endtask

    task automatic test_supply();
        mem[3] = make_record(1000, 1000, 1000, 1000, pack_date(1, 5));
        do_supply(8'd3, pack_date(2, 1), {12'd500, 12'd600, 12'd700, 12'd800});
        // black tea passes the top
        mem[4] = make_record(4000, 10, 10, 10, pack_date(1, 5));
        do_supply(8'd4, pack_date(3, 3), {12'd200, 12'd5, 12'd5, 12'd5});
    endtask

    task automatic test_check_date();
        do_check_date(8'd3, pack_date(2, 2));
        do_check_date(8'd3, pack_date(1, 31));
    endtask

    task automatic test_random();
        logic [7:0]  box;
        logic [8:0]  d;
        logic [47:0] sup;
        int          kind;
        for (int n = 0; n < 30; n++) begin
            box  = 8'(rand_between(0, 255));
            d    = pack_date(rand_between(1, 12), rand_between(1, 31));
            kind = rand_between(0, 2);
            if (kind == 0) begin
                do_make(box, bev_pkg::bev_type_t'(3'(rand_between(0, 7))),
                        bev_pkg::bev_size_t'(2'(rand_between(0, 2))), d);
            end else if (kind == 1) begin
                for (int i = 0; i < 4; i++) sup[i * 12 +: 12] = 12'(rand_between(0, 2047));
                do_supply(box, d, sup);
            end else begin
                do_check_date(box, d);
            end
        end
    endtask

    // dram answers each access after 1 to 8 cycles
    always begin
        @(negedge clk);
        if (rst_n && c_in_valid) begin
            req_addr  = c_addr;
            req_read  = c_r_wb;
            req_data  = c_data_w;
            req_delay = rand_between(1, 8);
            repeat (req_delay) @(negedge clk);
            if (req_read) begin
                c_data_r = mem[req_addr];
            end else begin
                mem[req_addr] = req_data;
                num_writes++;
            end
            resp_time   = $time;
            c_out_valid = 1'b1;
            @(negedge clk);
            c_out_valid = 1'b0;
        end
    end

    initial begin
        repeat (num_orders * cycles_per_order) @(posedge clk);
        $display("timeout: orders did not finish in %0d cycles", num_orders * cycles_per_order);
        $display("%0d checks, %0d errors", num_checks, num_errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed             = 32'hf3db_7896;
        rst_n            = 1'b0;
        sel_action_valid = 1'b0;
        action           = bev_pkg::make_drink;
        type_valid       = 1'b0;
        bev_type         = bev_pkg::black_tea;
        size_valid       = 1'b0;
        bev_size         = bev_pkg::size_l;
        date_valid       = 1'b0;
        date             = '0;
        box_no_valid     = 1'b0;
        box_no           = '0;
        box_sup_valid    = 1'b0;
        ing_sup          = '0;
        // boxes start with random stock and dates
        for (int i = 0; i < 256; i++) begin
            mem[i] = make_record(rand_between(0, 4095), rand_between(0, 4095),
                                 rand_between(0, 4095), rand_between(0, 4095),
                                 pack_date(rand_between(1, 12), rand_between(1, 28)));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_make_ok();
        test_make_fail();
        test_supply();
        test_check_date();
        test_random();
        repeat (2) @(negedge clk);
        $display("%0d checks, %0d errors", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
bev_pkg.sv
bev_order_ctrl.sv
bev_recipe.sv
bev_ing_lane.sv
bev_box_check.sv
bev_top.sv
tb_bev.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_bev
FILELIST  = files.f
BUILD_DIR = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
